// ==== include/slapfight_settings.svh ====
/*
 * Shell settings: bridge register map, core reset length and field widths.
 * Include this header wherever one of these values is needed.
 */
`ifndef SLAPFIGHT_SETTINGS_SVH
`define SLAPFIGHT_SETTINGS_SVH

// bridge register map
`define SLAP_ADDR_RESET     32'hF000_0000
`define SLAP_ADDR_DIP       32'hF100_0000
`define SLAP_ADDR_MODE      32'hF200_0000
`define SLAP_ADDR_SCNL      32'hF300_0000

// core reset length in clk_74a cycles
`define SLAP_RESET_HOLD     8000
// counter width, must hold SLAP_RESET_HOLD
`define SLAP_HOLD_W         14

// stored field widths
`define SLAP_SCNL_W         2
`define SLAP_MODE_W         8
`define SLAP_DIP_W          16
`define SLAP_DIP_BANK_W     8

// colour channel widths
`define SLAP_CH_IN_W        4
`define SLAP_CH_OUT_W       8

`endif

// ==== hw/shell_pkg.sv ====
/*
 * Shared types for the shell: bridge words, pixels, pads, the control
 * panel word and the setting fields. Modules import it in their bodies.
 */
`include "slapfight_settings.svh"

package shell_pkg;

    // bridge address and data
    typedef logic [31:0] bus_word_t;

    // core pixel, red in the high nibble
    typedef struct packed {
        logic [`SLAP_CH_IN_W-1:0] r;
        logic [`SLAP_CH_IN_W-1:0] g;
        logic [`SLAP_CH_IN_W-1:0] b;
    } rgb444_t;

    // scaler pixel, red in the high byte
    typedef struct packed {
        logic [`SLAP_CH_OUT_W-1:0] r;
        logic [`SLAP_CH_OUT_W-1:0] g;
        logic [`SLAP_CH_OUT_W-1:0] b;
    } rgb888_t;

    // controller key bitmap and the bits we use
    typedef logic [31:0] pad_key_t;
    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_B      = 5;
    localparam int KEY_Y      = 7;
    localparam int KEY_SELECT = 14;
    localparam int KEY_START  = 15;

    // control panel, coin at bit 8 down to right at bit 0
    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
        logic shoot2;
        logic shoot;
        logic up;
        logic down;
        logic left;
        logic right;
    } panel_t;

    typedef logic [`SLAP_DIP_BANK_W-1:0] dip_t;
    typedef logic [`SLAP_SCNL_W-1:0]     scnl_level_t;
    typedef logic [`SLAP_HOLD_W-1:0]     hold_count_t;

endpackage

// ==== hw/bridge_regs.sv ====
/*
 * Settings register bank on the bridge: reset, DIP, mode and scanlines.
 * Writes land one cycle after the strobe, reads return one cycle after
 * the strobe and hold until the next read.
 */
`timescale 1ns/1ps
`include "slapfight_settings.svh"

module bridge_regs (
    input  logic                           clk_74a,
    input  logic                           temp_reset,
    input  shell_pkg::bus_word_t           bridge_addr,
    input  logic                           bridge_rd,
    input  logic                           bridge_wr,
    input  shell_pkg::bus_word_t           bridge_wr_data,
    input  logic                           core_run,
    output shell_pkg::bus_word_t           bridge_rd_data,
    output logic                           core_reset_req,
    output shell_pkg::dip_t                dip_sw0,
    output shell_pkg::dip_t                dip_sw1,
    output logic [`SLAP_MODE_W-1:0]        core_mode,
    output shell_pkg::scnl_level_t         scanline_level
);
    import shell_pkg::*;

    logic [`SLAP_DIP_W-1:0]  dip_reg;
    logic [`SLAP_MODE_W-1:0] mode_reg;
    scnl_level_t             scnl_reg;

    logic hit_reset;
    logic hit_dip;
    logic hit_mode;
    logic hit_scnl;

    // address decode, shared by both paths
    assign hit_reset = (bridge_addr == `SLAP_ADDR_RESET);
    assign hit_dip   = (bridge_addr == `SLAP_ADDR_DIP);
    assign hit_mode  = (bridge_addr == `SLAP_ADDR_MODE);
    assign hit_scnl  = (bridge_addr == `SLAP_ADDR_SCNL);

    //////////////////////////////////////////////////
    // write side

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dip_reg        <= '0;
            mode_reg       <= '0;
            scnl_reg       <= '0;
            core_reset_req <= 1'b0;
        end else begin
            // new dips need a fresh core start too
            core_reset_req <= bridge_wr && (hit_reset || hit_dip);
            if (bridge_wr && hit_dip) begin
                dip_reg <= bridge_wr_data[`SLAP_DIP_W-1:0];
            end
            if (bridge_wr && hit_mode) begin
                mode_reg <= bridge_wr_data[`SLAP_MODE_W-1:0];
            end
            if (bridge_wr && hit_scnl) begin
                scnl_reg <= bridge_wr_data[`SLAP_SCNL_W-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // read side

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            if (hit_reset) begin
                bridge_rd_data <= bus_word_t'(core_run);
            end else if (hit_dip) begin
                bridge_rd_data <= bus_word_t'(dip_reg);
            end else if (hit_mode) begin
                bridge_rd_data <= bus_word_t'(mode_reg);
            end else if (hit_scnl) begin
                bridge_rd_data <= bus_word_t'(scnl_reg);
            end else begin
                bridge_rd_data <= '0;
            end
        end
    end

    // bank 0 low byte, bank 1 next byte
    assign dip_sw0        = dip_reg[`SLAP_DIP_BANK_W-1:0];
    assign dip_sw1        = dip_reg[`SLAP_DIP_W-1:`SLAP_DIP_BANK_W];
    assign core_mode      = mode_reg;
    assign scanline_level = scnl_reg;

    //////////////////////////////////////////////////
    // checks

    // host never reads and writes in the same cycle
    a_rd_wr_excl : assert property (@(posedge clk_74a) disable iff (temp_reset)
        !(bridge_rd && bridge_wr))
        else $error("bridge_rd and bridge_wr high together");

endmodule

// ==== hw/reset_stretcher.sv ====
/*
 * Holds the core in reset for SLAP_RESET_HOLD cycles after temp_reset
 * or a one-cycle request. A request during the hold restarts the count.
 */
`timescale 1ns/1ps
`include "slapfight_settings.svh"

module reset_stretcher (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic core_reset_req,
    output logic core_run
);
    import shell_pkg::*;

    hold_count_t hold_cnt;

    // core_run goes high in the same cycle the count hits zero
    always_ff @(posedge clk_74a) begin
        if (temp_reset || core_reset_req) begin
            hold_cnt <= hold_count_t'(`SLAP_RESET_HOLD);
            core_run <= 1'b0;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            core_run <= (hold_cnt == hold_count_t'(1));
        end else begin
            core_run <= 1'b1;
        end
    end

    // run only once the hold has fully expired
    a_run_after_hold : assert property (@(posedge clk_74a) disable iff (temp_reset)
        core_run |-> (hold_cnt == '0))
        else $error("core_run high with hold count %0d", hold_cnt);

endmodule

// ==== hw/panel_mapper.sv ====
/*
 * Merges the two player pads into the core's active-low control panel.
 * Shared buttons are the OR of both players, starts stay per player.
 * The panel word is registered, one cycle behind the pads.
 */
`timescale 1ns/1ps

module panel_mapper (
    input  logic                clk_74a,
    input  logic                temp_reset,
    input  shell_pkg::pad_key_t cont1_key,
    input  shell_pkg::pad_key_t cont2_key,
    output shell_pkg::panel_t   control_panel
);
    import shell_pkg::*;

    // active-high merge before inversion
    panel_t merged;

    always_comb begin
        // one coin input for both players
        merged.coin   = cont1_key[KEY_SELECT] | cont2_key[KEY_SELECT];

        // starts are separate
        merged.start2 = cont2_key[KEY_START];
        merged.start1 = cont1_key[KEY_START];

        // fire buttons
        merged.shoot2 = cont1_key[KEY_Y] | cont2_key[KEY_Y];
        merged.shoot  = cont1_key[KEY_B] | cont2_key[KEY_B];

        // directions
        merged.up     = cont1_key[KEY_UP]    | cont2_key[KEY_UP];
        merged.down   = cont1_key[KEY_DOWN]  | cont2_key[KEY_DOWN];
        merged.left   = cont1_key[KEY_LEFT]  | cont2_key[KEY_LEFT];
        merged.right  = cont1_key[KEY_RIGHT] | cont2_key[KEY_RIGHT];
    end

    //////////////////////////////////////////////////
    // output register, idle is all ones

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            control_panel <= '1;
        end else begin
            control_panel <= panel_t'(~merged);
        end
    end

endmodule

// ==== hw/video_formatter.sv ====
/*
 * Turns the core's RGB444 and sync/blank signals into the scaler stream.
 * Colour is widened to 24 bits, data enable comes from the blanks and odd
 * lines are darkened by the scanline level. All outputs lag by one cycle.
 */
`timescale 1ns/1ps

module video_formatter (
    input  logic                   clk_74a,
    input  logic                   temp_reset,
    input  shell_pkg::scnl_level_t scanline_level,
    input  shell_pkg::rgb444_t     core_rgb,
    input  logic                   core_hs,
    input  logic                   core_vs,
    input  logic                   core_hb,
    input  logic                   core_vb,
    output shell_pkg::rgb888_t     video_rgb,
    output logic                   video_hs,
    output logic                   video_vs,
    output logic                   video_de
);
    import shell_pkg::*;

    logic        hs_q;
    logic        vs_q;
    logic        line_odd;
    logic        line_odd_next;
    scnl_level_t shift;
    rgb888_t     wide;
    rgb888_t     dimmed;

    //////////////////////////////////////////////////
    // line parity

    // vs rise starts an even line, each hs rise flips it
    always_comb begin
        if (core_vs && !vs_q) begin
            line_odd_next = 1'b0;
        end else if (core_hs && !hs_q) begin
            line_odd_next = !line_odd;
        end else begin
            line_odd_next = line_odd;
        end
    end

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            line_odd <= 1'b0;
        end else begin
            hs_q     <= core_hs;
            vs_q     <= core_vs;
            line_odd <= line_odd_next;
        end
    end

    //////////////////////////////////////////////////
    // colour

    // nibble on top, low bits zero
    assign wide.r = {core_rgb.r, 4'h0};
    assign wide.g = {core_rgb.g, 4'h0};
    assign wide.b = {core_rgb.b, 4'h0};

    // even lines pass through untouched
    assign shift    = line_odd_next ? scanline_level : '0;
    assign dimmed.r = wide.r >> shift;
    assign dimmed.g = wide.g >> shift;
    assign dimmed.b = wide.b >> shift;

    //////////////////////////////////////////////////
    // output stage

    always_ff @(posedge clk_74a) begin
        video_rgb <= dimmed;
        if (temp_reset) begin
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else begin
            video_hs <= core_hs;
            video_vs <= core_vs;
            video_de <= !(core_hb || core_vb);
        end
    end

endmodule

// ==== hw/shell_top.sv ====
/*
 * Shell top level around the arcade core. Connects the settings bank to
 * the reset stretcher, the panel mapper and the video formatter; the core
 * itself hangs off the ports.
 */
`timescale 1ns/1ps
`include "slapfight_settings.svh"

module shell_top (
    input  logic                    clk_74a,
    input  logic                    temp_reset,

    // bridge
    input  shell_pkg::bus_word_t    bridge_addr,
    input  logic                    bridge_rd,
    input  logic                    bridge_wr,
    input  shell_pkg::bus_word_t    bridge_wr_data,
    output shell_pkg::bus_word_t    bridge_rd_data,

    // settings and run control to the core
    output shell_pkg::dip_t         dip_sw0,
    output shell_pkg::dip_t         dip_sw1,
    output logic [`SLAP_MODE_W-1:0] core_mode,
    output logic                    core_run,

    // pads
    input  shell_pkg::pad_key_t     cont1_key,
    input  shell_pkg::pad_key_t     cont2_key,
    output shell_pkg::panel_t       control_panel,

    // core video in, scaler video out
    input  shell_pkg::rgb444_t      core_rgb,
    input  logic                    core_hs,
    input  logic                    core_vs,
    input  logic                    core_hb,
    input  logic                    core_vb,
    output shell_pkg::rgb888_t      video_rgb,
    output logic                    video_hs,
    output logic                    video_vs,
    output logic                    video_de
);
    import shell_pkg::*;

    logic        core_reset_req;
    scnl_level_t scanline_level;

    //////////////////////////////////////////////////
    // control

    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .core_run       (core_run),
        .bridge_rd_data (bridge_rd_data),
        .core_reset_req (core_reset_req),
        .dip_sw0        (dip_sw0),
        .dip_sw1        (dip_sw1),
        .core_mode      (core_mode),
        .scanline_level (scanline_level)
    );

    reset_stretcher u_reset_stretcher (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .core_reset_req (core_reset_req),
        .core_run       (core_run)
    );

    //////////////////////////////////////////////////
    // datapath

    panel_mapper u_panel_mapper (
        .clk_74a       (clk_74a),
        .temp_reset    (temp_reset),
        .cont1_key     (cont1_key),
        .cont2_key     (cont2_key),
        .control_panel (control_panel)
    );

    video_formatter u_video_formatter (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .scanline_level (scanline_level),
        .core_rgb       (core_rgb),
        .core_hs        (core_hs),
        .core_vs        (core_vs),
        .core_hb        (core_hb),
        .core_vb        (core_vb),
        .video_rgb      (video_rgb),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .video_de       (video_de)
    );

endmodule

// ==== include/tb_shell_checks.svh ====
/*
 * Testbench helpers: typed compare tasks, error counters and the
 * pseudo-random source. Included inside the testbench module body.
 */
`ifndef TB_SHELL_CHECKS_SVH
`define TB_SHELL_CHECKS_SVH

int err_word  = 0;
int err_panel = 0;
int err_rgb   = 0;
int err_bit   = 0;
int err_other = 0;

int unsigned lcg_state = 40;

task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
        err_word++;
        $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_panel(input string name, input panel_t got, input panel_t exp);
    if (got !== exp) begin
        err_panel++;
        $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_rgb(input string name, input rgb888_t got, input rgb888_t exp);
    if (got !== exp) begin
        err_rgb++;
        $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        err_bit++;
        $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

function automatic int error_total();
    return err_word + err_panel + err_rgb + err_bit + err_other;
endfunction

task automatic report_counts();
    $display("errors: word %0d, panel %0d, rgb %0d, bit %0d, other %0d, total %0d",
             err_word, err_panel, err_rgb, err_bit, err_other, error_total());
endtask

// 32-bit LCG, full period constants
function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

`endif

// ==== bench/tb_shell_top.sv ====
/*
 * Testbench for shell_top: reset state, core reset timing, the bridge
 * register table, the pad merge and the video formatting.
 */
`timescale 1ns/1ps
`include "slapfight_settings.svh"

module tb_shell_top;
    import shell_pkg::*;
    `include "tb_shell_checks.svh"

    localparam int NUM_ROWS  = 10;
    localparam int NUM_PADS  = 64;
    localparam int LINE_LEN  = 16;
    // odd line count, so each vs rise has a set parity to clear
    localparam int FRAME_LEN = LINE_LEN * 5;
    localparam int NUM_VIDEO = FRAME_LEN * 4;
    localparam int LIMIT     = 3 * `SLAP_RESET_HOLD + 4 * NUM_ROWS + NUM_PADS + NUM_VIDEO + 200;

    // pads and syncs busy during reset, the outputs still have to idle
    logic      clk_74a        = 1'b0;
    logic      temp_reset     = 1'b1;
    bus_word_t bridge_addr    = '0;
    logic      bridge_rd      = 1'b0;
    logic      bridge_wr      = 1'b0;
    bus_word_t bridge_wr_data = '0;
    pad_key_t  cont1_key      = '1;
    pad_key_t  cont2_key      = '0;
    rgb444_t   core_rgb       = '0;
    logic      core_hs        = 1'b1;
    logic      core_vs        = 1'b1;
    logic      core_hb        = 1'b0;
    logic      core_vb        = 1'b0;

    bus_word_t bridge_rd_data;
    dip_t      dip_sw0;
    dip_t      dip_sw1;
    logic [7:0] core_mode;
    logic      core_run;
    panel_t    control_panel;
    rgb888_t   video_rgb;
    logic      video_hs;
    logic      video_vs;
    logic      video_de;

    // register table: address, write data, expected read value
    bus_word_t row_addr  [NUM_ROWS];
    bus_word_t row_wdata [NUM_ROWS];
    bus_word_t row_rdata [NUM_ROWS];

    int cycle_count = 0;

    shell_top UUT (.*);

    initial begin
        forever #2 clk_74a = ~clk_74a;
    end

    task automatic set_row(input int idx, input bus_word_t a, input bus_word_t w, input bus_word_t r);
        row_addr[idx]  = a;
        row_wdata[idx] = w;
        row_rdata[idx] = r;
    endtask

    task automatic bus_write(input bus_word_t addr, input bus_word_t data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
    endtask

    task automatic bus_read(input bus_word_t addr, output bus_word_t data);
        @(posedge clk_74a);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_rd <= 1'b0;
        @(negedge clk_74a);
        data = bridge_rd_data;
    endtask

    // edges until core_run is seen high, bounded
    task automatic wait_run(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_74a);
            cycles++;
            @(negedge clk_74a);
        end while (!core_run && cycles <= `SLAP_RESET_HOLD + 16);
        if (!core_run) begin
            err_other++;
            $display("core_run never came out of reset within %0d cycles", cycles);
        end
    endtask

    task automatic reset_command(input string name, input bus_word_t addr, input bus_word_t data);
        bus_word_t rd_val;
        int        cycles;
        bus_write(addr, data);
        @(negedge clk_74a);
        check_bit({name, " core_run before drop"}, core_run, 1'b1);
        // stretcher loads on this edge
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_bit({name, " core_run after drop"}, core_run, 1'b0);
        bus_read(`SLAP_ADDR_RESET, rd_val);
        check_word({name, " reset reg in hold"}, rd_val, 32'd0);
        // two edges already gone since the load
        wait_run(cycles);
        check_word({name, " hold length"}, bus_word_t'(cycles + 2),
                   bus_word_t'(`SLAP_RESET_HOLD));
        bus_read(`SLAP_ADDR_RESET, rd_val);
        check_word({name, " reset reg after hold"}, rd_val, 32'd1);
    endtask

    function automatic panel_t panel_model(input pad_key_t c1, input pad_key_t c2);
        panel_t p;
        p.coin   = c1[14] | c2[14];
        p.start2 = c2[15];
        p.start1 = c1[15];
        p.shoot2 = c1[7] | c2[7];
        p.shoot  = c1[5] | c2[5];
        p.up     = c1[0] | c2[0];
        p.down   = c1[1] | c2[1];
        p.left   = c1[2] | c2[2];
        p.right  = c1[3] | c2[3];
        return panel_t'(~p);
    endfunction

    function automatic rgb888_t widen_dim(input rgb444_t px, input int shift);
        rgb888_t w;
        w.r = {px.r, 4'h0} >> shift;
        w.g = {px.g, 4'h0} >> shift;
        w.b = {px.b, 4'h0} >> shift;
        return w;
    endfunction

    //////////////////////////////////////////////////
    // timeout

    initial begin
        while (cycle_count < LIMIT) begin
            @(posedge clk_74a);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", LIMIT);
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int         cycles;
        pad_key_t   key1;
        pad_key_t   key2;
        panel_t     exp_panel;
        panel_t     next_panel;
        rgb444_t    px;
        logic       hs;
        logic       vs;
        logic       hb;
        logic       vb;
        logic       odd;
        logic       prev_hs;
        logic       prev_vs;
        logic [2:0] exp_sync;
        logic [2:0] next_sync;
        rgb888_t    exp_rgb;
        rgb888_t    next_rgb;
        logic [15:0] model_dip;
        logic [7:0] model_mode;

        set_row(0, `SLAP_ADDR_MODE, 32'h1234_56A5, 32'h0000_00A5);
        set_row(1, `SLAP_ADDR_DIP,  32'hDEAD_BEEF, 32'h0000_BEEF);
        set_row(2, `SLAP_ADDR_SCNL, 32'hFFFF_FFFE, 32'h0000_0002);
        set_row(3, 32'hF400_0000,   32'h5555_5555, 32'h0000_0000);
        set_row(4, `SLAP_ADDR_DIP,  32'h0000_3C81, 32'h0000_3C81);
        set_row(5, `SLAP_ADDR_SCNL, 32'h0000_0003, 32'h0000_0003);
        set_row(6, 32'hF100_0004,   32'hFFFF_FFFF, 32'h0000_0000);
        set_row(7, `SLAP_ADDR_MODE, 32'h0000_0000, 32'h0000_0000);
        set_row(8, 32'h0000_0000,   32'h0000_0001, 32'h0000_0000);
        set_row(9, `SLAP_ADDR_SCNL, 32'h8000_0001, 32'h0000_0001);

        // reset state, then the first core start
        repeat (7) @(posedge clk_74a);
        @(negedge clk_74a);
        check_panel("control_panel", control_panel, '1);
        check_word("bridge_rd_data", bridge_rd_data, 32'd0);
        check_bit("video_de", video_de, 1'b0);
        check_bit("video_hs", video_hs, 1'b0);
        check_bit("video_vs", video_vs, 1'b0);
        check_bit("core_run", core_run, 1'b0);
        @(posedge clk_74a);
        temp_reset <= 1'b0;
        core_hs    <= 1'b0;
        core_vs    <= 1'b0;
        wait_run(cycles);
        check_word("core_run delay", bus_word_t'(cycles), bus_word_t'(`SLAP_RESET_HOLD));

        reset_command("reset write", `SLAP_ADDR_RESET, 32'h0000_0001);
        reset_command("dip write", `SLAP_ADDR_DIP, 32'h0000_C35A);

        // write, read back one cycle later, then check the value holds
        model_dip  = 16'hC35A;
        model_mode = 8'h00;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk_74a);
            bridge_addr    <= row_addr[i];
            bridge_wr_data <= row_wdata[i];
            bridge_wr      <= 1'b1;
            @(posedge clk_74a);
            bridge_wr <= 1'b0;
            bridge_rd <= 1'b1;
            @(posedge clk_74a);
            bridge_rd <= 1'b0;
            @(negedge clk_74a);
            if (row_addr[i] == `SLAP_ADDR_DIP) begin
                model_dip = row_wdata[i][15:0];
            end
            if (row_addr[i] == `SLAP_ADDR_MODE) begin
                model_mode = row_wdata[i][7:0];
            end
            check_word("bridge_rd_data", bridge_rd_data, row_rdata[i]);
            check_word("dip_sw0", bus_word_t'(dip_sw0), bus_word_t'(model_dip[7:0]));
            check_word("dip_sw1", bus_word_t'(dip_sw1), bus_word_t'(model_dip[15:8]));
            check_word("core_mode", bus_word_t'(core_mode), bus_word_t'(model_mode));
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_word("bridge_rd_data held", bridge_rd_data, row_rdata[i]);
        end

        // pads, one new pair per cycle, checked one cycle later
        for (int i = 0; i <= NUM_PADS; i++) begin
            @(posedge clk_74a);
            if (i < NUM_PADS) begin
                key1 = lcg_next();
                key2 = lcg_next();
                cont1_key  <= key1;
                cont2_key  <= key2;
                next_panel = panel_model(key1, key2);
            end
            @(negedge clk_74a);
            if (i > 0) begin
                check_panel("control_panel", control_panel, exp_panel);
            end
            exp_panel = next_panel;
        end

        // one small frame per scanline level
        odd     = 1'b0;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        for (int lvl = 0; lvl < 4; lvl++) begin
            bus_write(`SLAP_ADDR_SCNL, bus_word_t'(lvl));
            for (int i = 0; i <= FRAME_LEN; i++) begin
                @(posedge clk_74a);
                if (i < FRAME_LEN) begin
                    px = rgb444_t'(lcg_next() >> 12);
                    hs = (i % LINE_LEN) >= 12 && (i % LINE_LEN) < 14;
                    hb = (i % LINE_LEN) >= 11;
                    vs = (i / LINE_LEN) == 0;
                    vb = (i / LINE_LEN) < 2;
                    core_rgb <= px;
                    core_hs  <= hs;
                    core_vs  <= vs;
                    core_hb  <= hb;
                    core_vb  <= vb;
                    if (vs && !prev_vs) begin
                        odd = 1'b0;
                    end else if (hs && !prev_hs) begin
                        odd = !odd;
                    end
                    prev_hs   = hs;
                    prev_vs   = vs;
                    next_rgb  = widen_dim(px, odd ? lvl : 0);
                    next_sync = {hs, vs, !(hb || vb)};
                end
                @(negedge clk_74a);
                if (i > 0) begin
                    check_rgb("video_rgb", video_rgb, exp_rgb);
                    check_bit("video_hs", video_hs, exp_sync[2]);
                    check_bit("video_vs", video_vs, exp_sync[1]);
                    check_bit("video_de", video_de, exp_sync[0]);
                end
                exp_rgb  = next_rgb;
                exp_sync = next_sync;
            end
        end

        report_counts();
        if (error_total() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== slapfight_shell.f ====
+incdir+include
hw/shell_pkg.sv
hw/bridge_regs.sv
hw/reset_stretcher.sv
hw/panel_mapper.sv
hw/video_formatter.sv
hw/shell_top.sv
bench/tb_shell_top.sv
